/* src/soc_pkg.sv */
package soc_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // top address nibble picks the region
  localparam int REGION_HI = 31;
  localparam int REGION_LO = 28;

  localparam logic [REGION_HI-REGION_LO:0] RAM_REGION = 4'h0; // 0x0000_0000
  localparam logic [REGION_HI-REGION_LO:0] LED_REGION = 4'h8; // 0x8000_0000
  localparam logic [REGION_HI-REGION_LO:0] KEY_REGION = 4'hC; // 0xC000_0000

  // on-chip RAM indexed by adr[9:2]
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = 8;

  // peripherals
  localparam int LED_W        = 8;
  localparam int KEY_W        = 2;
  localparam int KEY_FLAG_LSB = 16; // sticky flags in key read word

  // decoder target
  typedef enum logic [1:0] {
    SLV_RAM,
    SLV_LED,
    SLV_KEY,
    SLV_NONE
  } slave_sel_e;

endpackage

/* src/wb_if.sv */
`timescale 1ns/1ps

interface wb_if;
  import soc_pkg::*;

  logic              cyc;
  logic              stb;
  logic              we;
  logic [SEL_W-1:0]  sel;
  logic [ADDR_W-1:0] adr;
  logic [DATA_W-1:0] dat_w;

  logic              ack;
  logic              err;
  logic [DATA_W-1:0] dat_r;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  ack, err, dat_r
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output ack, err, dat_r
  );

endinterface

/* src/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [soc_pkg::SEL_W-1:0]  sel_i,
  input  logic [soc_pkg::ADDR_W-1:0] adr_i,
  input  logic [soc_pkg::DATA_W-1:0] dat_i,
  output logic                       ack_o,
  output logic                       err_o,
  output logic [soc_pkg::DATA_W-1:0] dat_o,
  wb_if.master                       ram_bus,
  wb_if.master                       led_bus,
  wb_if.master                       key_bus
);
  import soc_pkg::*;

  slave_sel_e target;
  logic       none_err_q;

  always_comb
  begin
    case (adr_i[REGION_HI:REGION_LO])
      RAM_REGION: target = SLV_RAM;
      LED_REGION: target = SLV_LED;
      KEY_REGION: target = SLV_KEY;
      default:    target = SLV_NONE;
    endcase
  end

  // strobes only to the selected slave
  assign ram_bus.cyc = cyc_i && (target == SLV_RAM);
  assign ram_bus.stb = stb_i && (target == SLV_RAM);
  assign led_bus.cyc = cyc_i && (target == SLV_LED);
  assign led_bus.stb = stb_i && (target == SLV_LED);
  assign key_bus.cyc = cyc_i && (target == SLV_KEY);
  assign key_bus.stb = stb_i && (target == SLV_KEY);

  // rest of the request is broadcast
  assign ram_bus.we    = we_i;
  assign ram_bus.sel   = sel_i;
  assign ram_bus.adr   = adr_i;
  assign ram_bus.dat_w = dat_i;
  assign led_bus.we    = we_i;
  assign led_bus.sel   = sel_i;
  assign led_bus.adr   = adr_i;
  assign led_bus.dat_w = dat_i;
  assign key_bus.we    = we_i;
  assign key_bus.sel   = sel_i;
  assign key_bus.adr   = adr_i;
  assign key_bus.dat_w = dat_i;

  // unmapped region answers like a slave one cycle later
  always_ff @(posedge clk)
  begin
    if (rst_i)
      none_err_q <= 1'b0;
    else
      none_err_q <= cyc_i && stb_i && (target == SLV_NONE) && !none_err_q;
  end

  always_comb
  begin
    case (target)
      SLV_RAM:
      begin
        ack_o = ram_bus.ack;
        err_o = ram_bus.err;
        dat_o = ram_bus.dat_r;
      end
      SLV_LED:
      begin
        ack_o = led_bus.ack;
        err_o = led_bus.err;
        dat_o = led_bus.dat_r;
      end
      SLV_KEY:
      begin
        ack_o = key_bus.ack;
        err_o = key_bus.err;
        dat_o = key_bus.dat_r;
      end
      default:
      begin
        ack_o = 1'b0;
        err_o = none_err_q;
        dat_o = '0; // err carries no data
      end
    endcase
  end

  assert property (@(posedge clk) disable iff (rst_i)
    $onehot0({ram_bus.stb, led_bus.stb, key_bus.stb}));

  // slave acks and decoder err must never collide
  assert property (@(posedge clk) disable iff (rst_i) !(ack_o && err_o));

endmodule

/* src/onchip_ram.sv */
`timescale 1ns/1ps

module onchip_ram (
  input  logic clk,
  input  logic rst_i,
  wb_if.slave  bus
);
  import soc_pkg::*;

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic [DATA_W-1:0] wr_word;
  logic [DATA_W-1:0] rd_q;
  logic              ack_q;
  logic              req;

  assign idx = bus.adr[RAM_AW+1:2]; // upper bits alias
  assign req = bus.cyc && bus.stb && !ack_q;

  // merge selected bytes into the stored word
  always_comb
  begin
    wr_word = mem[idx];
    for (int b = 0; b < SEL_W; b++)
    begin
      if (bus.we && bus.sel[b])
        wr_word[8*b +: 8] = bus.dat_w[8*b +: 8];
    end
  end

  always_ff @(posedge clk)
  begin
    if (req)
    begin
      if (bus.we)
        mem[idx] <= wr_word;
      rd_q <= wr_word; // read sees this cycle's write
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= req;
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = rd_q;

  assert property (@(posedge clk) disable iff (rst_i) bus.ack |=> !bus.ack);

endmodule

/* src/led_reg.sv */
`timescale 1ns/1ps

module led_reg (
  input  logic                      clk,
  input  logic                      rst_i,
  wb_if.slave                       bus,
  output logic [soc_pkg::LED_W-1:0] led_o
);
  import soc_pkg::*;

  logic [LED_W-1:0] led_q;
  logic             ack_q;
  logic             req;

  assign req = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      led_q <= '0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= req;
      if (req && bus.we && bus.sel[0]) // low byte only
        led_q <= bus.dat_w[LED_W-1:0];
    end
  end

  assign led_o     = led_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = {{(DATA_W-LED_W){1'b0}}, led_q};

  assert property (@(posedge clk) disable iff (rst_i) bus.ack |=> !bus.ack);

endmodule

/* src/key_port.sv */
`timescale 1ns/1ps

module key_port (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [soc_pkg::KEY_W-1:0] key_n_i,
  wb_if.slave                       bus
);
  import soc_pkg::*;

  logic [KEY_W-1:0]  meta_q;    // first sync stage
  logic [KEY_W-1:0]  pressed_q;
  logic [KEY_W-1:0]  prev_q;
  logic [KEY_W-1:0]  flag_q;
  logic [KEY_W-1:0]  set;
  logic [KEY_W-1:0]  clr;
  logic              ack_q;
  logic              req;
  logic [DATA_W-1:0] rd_word;

  assign req = bus.cyc && bus.stb && !ack_q;
  assign set = pressed_q & ~prev_q;

  // write one to clear when the flag byte is selected
  assign clr = (req && bus.we && bus.sel[KEY_FLAG_LSB/8]) ?
               bus.dat_w[KEY_FLAG_LSB +: KEY_W] : '0;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      meta_q    <= '0;
      pressed_q <= '0;
      prev_q    <= '0;
      flag_q    <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      meta_q    <= ~key_n_i; // keys are active low
      pressed_q <= meta_q;
      prev_q    <= pressed_q;
      flag_q    <= (flag_q & ~clr) | set; // set wins
      ack_q     <= req;
    end
  end

  always_comb
  begin
    rd_word                            = '0;
    rd_word[KEY_W-1:0]                 = pressed_q;
    rd_word[KEY_FLAG_LSB +: KEY_W]     = flag_q;
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = rd_word;

endmodule

/* src/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [soc_pkg::SEL_W-1:0]  sel_i,
  input  logic [soc_pkg::ADDR_W-1:0] adr_i,
  input  logic [soc_pkg::DATA_W-1:0] dat_i,
  input  logic [soc_pkg::KEY_W-1:0]  key_n_i,
  output logic                       ack_o,
  output logic                       err_o,
  output logic [soc_pkg::DATA_W-1:0] dat_o,
  output logic [soc_pkg::LED_W-1:0]  led_o
);

  wb_if ram_bus ();
  wb_if led_bus ();
  wb_if key_bus ();

  bus_decoder u_decoder (
    .clk     (clk),
    .rst_i   (rst_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .sel_i   (sel_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .ack_o   (ack_o),
    .err_o   (err_o),
    .dat_o   (dat_o),
    .ram_bus (ram_bus.master),
    .led_bus (led_bus.master),
    .key_bus (key_bus.master)
  );

  onchip_ram u_ram (
    .clk   (clk),
    .rst_i (rst_i),
    .bus   (ram_bus.slave)
  );

  led_reg u_led (
    .clk   (clk),
    .rst_i (rst_i),
    .bus   (led_bus.slave),
    .led_o (led_o)
  );

  key_port u_key (
    .clk     (clk),
    .rst_i   (rst_i),
    .key_n_i (key_n_i),
    .bus     (key_bus.slave)
  );

endmodule

/* verification/tb_soc_bus_top.sv */
`timescale 1ns/1ps

module tb_soc_bus_top;
  import soc_pkg::*;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_KEY} op_e;
  typedef enum logic [1:0] {CHK_NONE, CHK_TABLE, CHK_MODEL} chk_e;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    logic [KEY_W-1:0]  key_n;
    logic [DATA_W-1:0] exp;
    logic              exp_err;
    chk_e              chk;
    logic              rnd;   // write data from the lfsr
  } step_t;

  logic              clk;
  logic              rst_i;
  logic              cyc_i;
  logic              stb_i;
  logic              we_i;
  logic [SEL_W-1:0]  sel_i;
  logic [ADDR_W-1:0] adr_i;
  logic [DATA_W-1:0] dat_i;
  logic [KEY_W-1:0]  key_n_i;
  logic              ack_o;
  logic              err_o;
  logic [DATA_W-1:0] dat_o;
  logic [LED_W-1:0]  led_o;

  step_t             steps [$];
  logic [DATA_W-1:0] ram_model [RAM_WORDS];
  logic [LED_W-1:0]  led_exp;
  logic [31:0]       lfsr_q;
  int                err_cnt;
  int                chk_cnt;
  int                limit_cycles;

  soc_bus_top dut (
    .clk     (clk),
    .rst_i   (rst_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .sel_i   (sel_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .key_n_i (key_n_i),
    .ack_o   (ack_o),
    .err_o   (err_o),
    .dat_o   (dat_o),
    .led_o   (led_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_W; i++)
      w = {w[DATA_W-2:0], lfsr_bit()};
    return w;
  endfunction

  function automatic slave_sel_e target_of(input logic [ADDR_W-1:0] adr);
    case (adr[REGION_HI:REGION_LO])
      RAM_REGION: return SLV_RAM;
      LED_REGION: return SLV_LED;
      KEY_REGION: return SLV_KEY;
      default:    return SLV_NONE;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic add_read(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] exp,
                          input logic exp_err, input chk_e chk);
    steps.push_back('{OP_RD, adr, '0, '1, '1, exp, exp_err, chk, 1'b0});
  endtask

  task automatic add_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                           input logic [SEL_W-1:0] sel, input logic exp_err,
                           input logic rnd);
    chk_e chk;
    chk = exp_err ? CHK_TABLE : CHK_NONE; // err response must carry zero data
    steps.push_back('{OP_WR, adr, dat, sel, '1, '0, exp_err, chk, rnd});
  endtask

  task automatic add_key(input logic [KEY_W-1:0] key_n);
    steps.push_back('{OP_KEY, '0, '0, '0, key_n, '0, 1'b0, CHK_NONE, 1'b0});
  endtask

  task automatic build_table();
    add_read(32'hC000_0000, 32'h0000_0000, 1'b0, CHK_TABLE);  // no flags after reset
    add_read(32'h8000_0000, 32'h0000_0000, 1'b0, CHK_TABLE);
    add_write(32'h0000_0000, 32'h0, 4'hF, 1'b0, 1'b1);
    add_write(32'h0000_0004, 32'h0, 4'hF, 1'b0, 1'b1);
    add_write(32'h0000_03FC, 32'h0, 4'hF, 1'b0, 1'b1);       // last word
    add_read(32'h0000_0000, 32'h0, 1'b0, CHK_MODEL);
    add_read(32'h0000_0004, 32'h0, 1'b0, CHK_MODEL);
    add_read(32'h0000_03FC, 32'h0, 1'b0, CHK_MODEL);
    add_write(32'h0000_0004, 32'h0, 4'b0101, 1'b0, 1'b1);    // partial writes
    add_write(32'h0000_0000, 32'h0, 4'b1000, 1'b0, 1'b1);
    add_read(32'h0000_0004, 32'h0, 1'b0, CHK_MODEL);
    add_read(32'h0000_0000, 32'h0, 1'b0, CHK_MODEL);
    add_read(32'h0FF0_0004, 32'h0, 1'b0, CHK_MODEL);          // alias of word 1
    add_write(32'h0123_0400, 32'h0, 4'hF, 1'b0, 1'b1);       // alias of word 0
    add_read(32'h0000_0000, 32'h0, 1'b0, CHK_MODEL);
    add_write(32'h8000_0000, 32'h0000_00A5, 4'b0001, 1'b0, 1'b0);
    add_read(32'h8000_0000, 32'h0000_00A5, 1'b0, CHK_TABLE);
    add_write(32'h8000_0004, 32'h0000_005A, 4'b1110, 1'b0, 1'b0);
    add_read(32'h8000_0010, 32'h0000_00A5, 1'b0, CHK_TABLE);
    add_key(2'b10);                                           // key 0 down
    add_read(32'hC000_0000, 32'h0001_0001, 1'b0, CHK_TABLE);
    add_key(2'b11);
    add_read(32'hC000_0000, 32'h0001_0000, 1'b0, CHK_TABLE);
    add_write(32'hC000_0000, 32'h0000_0000, 4'hF, 1'b0, 1'b0); // zero keeps the flag
    add_read(32'hC000_0000, 32'h0001_0000, 1'b0, CHK_TABLE);
    add_write(32'hC000_0000, 32'h0001_0000, 4'hF, 1'b0, 1'b0);
    add_read(32'hC000_0000, 32'h0000_0000, 1'b0, CHK_TABLE);
    add_key(2'b01);                                           // key 1 down
    add_read(32'hC000_0000, 32'h0002_0002, 1'b0, CHK_TABLE);
    add_key(2'b11);
    add_read(32'hC000_0000, 32'h0002_0000, 1'b0, CHK_TABLE);
    add_read(32'h4000_0000, 32'h0000_0000, 1'b1, CHK_TABLE);  // unmapped
    add_write(32'h4000_0000, 32'hFFFF_FFFF, 4'hF, 1'b1, 1'b0);
    add_read(32'h8000_0000, 32'h0000_00A5, 1'b0, CHK_TABLE);
    add_read(32'h0000_0000, 32'h0, 1'b0, CHK_MODEL);
    add_read(32'h0000_03FC, 32'h0, 1'b0, CHK_MODEL);
  endtask

  task automatic set_keys(input logic [KEY_W-1:0] level);
    @(posedge clk);
    #5;
    key_n_i = level;
    repeat (4) @(posedge clk); // two sync flops plus edge detect
  endtask

  task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                          output logic [DATA_W-1:0] rdat, output logic rack,
                          output logic rerr);
    int waited;
    waited = 0;
    rack   = 1'b0;
    rerr   = 1'b0;
    rdat   = '0;
    @(posedge clk);
    #5;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    sel_i = sel;
    adr_i = adr;
    dat_i = dat;
    @(negedge clk);
    check_val("ack_o before sampling edge", 32'(ack_o), 32'd0);
    check_val("err_o before sampling edge", 32'(err_o), 32'd0);
    while (!(rack || rerr) && waited < 4)
    begin
      @(posedge clk);
      waited++;
      @(negedge clk);
      rack = ack_o;
      rerr = err_o;
      rdat = dat_o;
    end
    if (!(rack || rerr))
    begin
      $display("no response from the DUT for address %h within %0d cycles", adr, waited);
      err_cnt++;
    end
    else
      check_val("response latency", 32'(waited), 32'd1);
    @(posedge clk);
    #5;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk);
    check_val("ack_o pulse width", 32'(ack_o), 32'd0);
    check_val("err_o pulse width", 32'(err_o), 32'd0);
  endtask

  initial
  begin
    step_t             st;
    slave_sel_e        tgt;
    string             tname;
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;
    logic              rack;
    logic              rerr;
    logic [RAM_AW-1:0] idx;

    rst_i   = 1'b1;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    sel_i   = '0;
    adr_i   = '0;
    dat_i   = '0;
    key_n_i = '1;   // keys released
    err_cnt = 0;
    chk_cnt = 0;
    lfsr_q  = 32'hc4987898;
    led_exp = '0;
    build_table();
    limit_cycles = steps.size() * 8 + 20;

    repeat (4) @(posedge clk);
    #5;
    rst_i = 1'b0;
    @(negedge clk);
    check_val("ack_o after reset", 32'(ack_o), 32'd0);
    check_val("err_o after reset", 32'(err_o), 32'd0);
    check_val("led_o after reset", 32'(led_o), 32'd0);

    foreach (steps[i])
    begin
      st    = steps[i];
      tgt   = target_of(st.adr);
      tname = tgt.name();
      if (st.op == OP_KEY)
        set_keys(st.key_n);
      else
      begin
        wdat = st.rnd ? rand_word() : st.dat;
        bus_xfer(st.op == OP_WR, st.adr, wdat, st.sel, rdat, rack, rerr);
        check_val({tname, " err_o"}, 32'(rerr), 32'(st.exp_err));
        check_val({tname, " ack_o"}, 32'(rack), 32'(!st.exp_err));
        idx = st.adr[RAM_AW+1:2];
        if (st.chk == CHK_TABLE)
          check_val({tname, " dat_o"}, rdat, st.exp);
        else if (st.chk == CHK_MODEL)
          check_val({tname, " dat_o"}, rdat, ram_model[idx]);
        if (st.op == OP_WR && !st.exp_err && st.adr[REGION_HI:REGION_LO] == RAM_REGION)
        begin
          for (int b = 0; b < SEL_W; b++)
            if (st.sel[b])
              ram_model[idx][8*b +: 8] = wdat[8*b +: 8];
        end
        if (st.op == OP_WR && !st.exp_err && st.adr[REGION_HI:REGION_LO] == LED_REGION
            && st.sel[0])
          led_exp = wdat[LED_W-1:0];
        check_val("led_o", 32'(led_o), 32'(led_exp));
      end
    end

    $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // watchdog sized from the table length
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
src/soc_pkg.sv
src/wb_if.sv
src/bus_decoder.sv
src/onchip_ram.sv
src/led_reg.sv
src/key_port.sv
src/soc_bus_top.sv
verification/tb_soc_bus_top.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_soc_bus_top
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TESTS PASSED$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
